// ==== hw/ecl_pkg.sv ====
package ecl_pkg;

   //////////////////////////////////////////////////////////////////////
   // register file indexing
   //////////////////////////////////////////////////////////////////////

   // 32 integer registers, r0 hardwired to zero
   localparam int REG_IDX_W = 5;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   //////////////////////////////////////////////////////////////////////
   // exception codes
   //////////////////////////////////////////////////////////////////////

   localparam int EXC_W = 6;

   // interrupt shares code 0
   // the rest come in from fetch, except ALE from the lsu
   typedef enum logic [EXC_W-1:0] {
      EXC_INT = 6'h00,
      EXC_PIL = 6'h01,
      EXC_PIS = 6'h02,
      EXC_PIF = 6'h03,
      EXC_PME = 6'h04,
      EXC_PPI = 6'h07,
      EXC_ADE = 6'h08,
      EXC_ALE = 6'h09,
      EXC_SYS = 6'h0b,
      EXC_BRK = 6'h0c,
      EXC_INE = 6'h0d,
      EXC_IPE = 6'h0e
   } exc_code_e;

   //////////////////////////////////////////////////////////////////////
   // writeback source and lsu stall state
   //////////////////////////////////////////////////////////////////////

   // priority lsu > mul > csr > alu
   typedef enum logic [1:0] {
      WB_ALU = 2'd0,
      WB_LSU = 2'd1,
      WB_MUL = 2'd2,
      WB_CSR = 2'd3
   } wb_src_e;

   typedef enum logic {
      LSU_IDLE = 1'b0,
      LSU_BUSY = 1'b1
   } lsu_state_e;

endpackage

// ==== hw/ecl_operand_bypass.sv ====
module ecl_operand_bypass #(
   parameter int XLEN = 32
) (
   // source indices and issued operands
   input  ecl_pkg::reg_idx_t rs1_e,
   input  ecl_pkg::reg_idx_t rs2_e,
   input  logic [XLEN-1:0]   alu_a_e,
   input  logic [XLEN-1:0]   alu_b_e,
   input  logic              alu_b_imm_e,
   input  logic              double_read_e,
   input  logic [XLEN-1:0]   imm_shifted_e,
   // m stage result
   input  ecl_pkg::reg_idx_t rd_m,
   input  logic              wen_m,
   input  logic [XLEN-1:0]   rd_data_m,
   // w stage result
   input  ecl_pkg::reg_idx_t rd_w,
   input  logic              wen_w,
   input  logic [XLEN-1:0]   rd_data_w,
   // forwarded operands
   output logic [XLEN-1:0]   alu_a,
   output logic [XLEN-1:0]   alu_b,
   output logic [XLEN-1:0]   lsu_base,
   output logic [XLEN-1:0]   lsu_offset,
   output logic [XLEN-1:0]   lsu_wdata
);
   import ecl_pkg::*;

   // select bits {from m, from w}, zero means issued value
   function automatic logic [1:0] fwd_sel(
      input reg_idx_t rs,
      input reg_idx_t m_rd,
      input logic     m_wen,
      input reg_idx_t w_rd,
      input logic     w_wen
   );
      logic hit_m;
      logic hit_w;
      // r0 reads as zero, never forward it
      hit_m = m_wen && (rs == m_rd) && (rs != '0);
      // younger result in m wins over w
      hit_w = w_wen && (rs == w_rd) && (rs != '0) && !hit_m;
      return {hit_m, hit_w};
   endfunction

   function automatic logic [XLEN-1:0] fwd_mux(
      input logic [1:0]      sel,
      input logic [XLEN-1:0] issued,
      input logic [XLEN-1:0] m_data,
      input logic [XLEN-1:0] w_data
   );
      logic [XLEN-1:0] res;
      res = issued;
      if (sel[1])
         res = m_data;
      else if (sel[0])
         res = w_data;
      return res;
   endfunction

   logic [1:0]      rs1_sel;
   logic [1:0]      rs2_sel;
   logic            use_issued_b;
   logic [XLEN-1:0] rs1_fwd;
   logic [XLEN-1:0] rs2_fwd;

   // immediate or double-read form, src2 is not a register read here
   assign use_issued_b = alu_b_imm_e | double_read_e;

   assign rs1_sel = fwd_sel(rs1_e, rd_m, wen_m, rd_w, wen_w);
   assign rs2_sel = use_issued_b ? 2'b00 : fwd_sel(rs2_e, rd_m, wen_m, rd_w, wen_w);

   assign rs1_fwd = fwd_mux(rs1_sel, alu_a_e, rd_data_m, rd_data_w);
   assign rs2_fwd = fwd_mux(rs2_sel, alu_b_e, rd_data_m, rd_data_w);

   // alu operands
   assign alu_a = rs1_fwd;
   assign alu_b = rs2_fwd;

   // lsu address and store data
   assign lsu_base   = rs1_fwd;
   assign lsu_offset = double_read_e ? rs2_fwd : imm_shifted_e;
   assign lsu_wdata  = rs2_fwd;

endmodule

// ==== hw/ecl_writeback.sv ====
module ecl_writeback #(
   parameter int XLEN = 32
) (
   input  logic              clk,
   input  logic              arst_n,
   // trap control
   input  logic              kill_e,
   input  logic              lsu_go,
   // alu at e
   input  ecl_pkg::reg_idx_t rf_target_e,
   input  logic              alu_wen_e,
   input  logic [XLEN-1:0]   alu_res_e,
   // multiplier, result arrives at m
   input  logic              mul_valid_e,
   input  logic              mul_wen_e,
   input  logic [XLEN-1:0]   mul_res_m,
   // csr read, data arrives at d
   input  logic              csr_valid_e,
   input  logic              csr_rdwen_e,
   input  logic [XLEN-1:0]   csr_rdata_d,
   // load/store
   input  ecl_pkg::reg_idx_t lsu_rd_e,
   input  logic              lsu_wen_e,
   input  logic              lsu_data_valid,
   input  logic [XLEN-1:0]   lsu_rdata_m,
   // gated multiplier valid toward the unit
   output logic              mul_valid,
   // m stage result
   output ecl_pkg::reg_idx_t rd_m,
   output logic              wen_m,
   output logic [XLEN-1:0]   rd_data_m,
   // w stage result, feeds the register file
   output ecl_pkg::reg_idx_t rd_w,
   output logic              wen_w,
   output logic [XLEN-1:0]   rd_data_w
);
   import ecl_pkg::*;

   reg_idx_t        rf_target_m;
   logic            alu_wen_m;
   logic [XLEN-1:0] alu_res_m;
   logic            mul_valid_m;
   logic            mul_wen_m;
   logic            csr_valid_m;
   logic            csr_rdwen_m;
   logic [XLEN-1:0] csr_rdata_e;
   logic [XLEN-1:0] csr_rdata_m;
   reg_idx_t        lsu_rd_m;
   logic            lsu_wen_m;
   wb_src_e         wb_src;

   // killed instruction leaves no trace in the pipe
   assign mul_valid = mul_valid_e & ~kill_e;

   //////////////////////////////////////////////////////////////////////
   // e to m registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rf_target_m <= '0;
         alu_wen_m   <= 1'b0;
         alu_res_m   <= '0;
         mul_valid_m <= 1'b0;
         mul_wen_m   <= 1'b0;
         csr_valid_m <= 1'b0;
         csr_rdwen_m <= 1'b0;
         csr_rdata_e <= '0;
         csr_rdata_m <= '0;
      end else begin
         // mul and csr reads share the alu target
         rf_target_m <= rf_target_e;
         alu_wen_m   <= alu_wen_e & ~kill_e;
         alu_res_m   <= alu_res_e;
         mul_valid_m <= mul_valid;
         mul_wen_m   <= mul_wen_e & ~kill_e;
         csr_valid_m <= csr_valid_e & ~kill_e;
         csr_rdwen_m <= csr_rdwen_e & ~kill_e;
         // csr data is read at d, two hops to m
         csr_rdata_e <= csr_rdata_d;
         csr_rdata_m <= csr_rdata_e;
      end
   end

   // load latency is open ended
   // hold its destination until data comes back
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lsu_rd_m  <= '0;
         lsu_wen_m <= 1'b0;
      end else if (lsu_go) begin
         lsu_rd_m  <= lsu_rd_e;
         lsu_wen_m <= lsu_wen_e;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // m stage select
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      if (lsu_data_valid)
         wb_src = WB_LSU;
      else if (mul_valid_m)
         wb_src = WB_MUL;
      else if (csr_valid_m)
         wb_src = WB_CSR;
      else
         wb_src = WB_ALU;
   end

   // load data overrides the alu slot
   assign rd_m = (wb_src == WB_LSU) ? lsu_rd_m : rf_target_m;

   // any unit may claim the write
   assign wen_m = alu_wen_m | mul_wen_m | csr_rdwen_m | (lsu_wen_m & lsu_data_valid);

   always_comb begin
      case (wb_src)
         WB_LSU:  rd_data_m = lsu_rdata_m;
         WB_MUL:  rd_data_m = mul_res_m;
         WB_CSR:  rd_data_m = csr_rdata_m;
         default: rd_data_m = alu_res_m;
      endcase
   end

   // m to w
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_w      <= '0;
         wen_w     <= 1'b0;
         rd_data_w <= '0;
      end else begin
         rd_w      <= rd_m;
         wen_w     <= wen_m;
         rd_data_w <= rd_data_m;
      end
   end

endmodule

// ==== hw/ecl_trap_ctrl.sv ====
module ecl_trap_ctrl (
   input  logic                clk,
   input  logic                arst_n,
   // issue
   input  logic                valid_e,
   input  logic                exception_e,
   input  ecl_pkg::exc_code_e  exccode_e,
   // interrupt sources and global enable
   input  logic                timer_intr,
   input  logic                ext_intr,
   input  logic                crmd_ie,
   // load/store
   input  logic                lsu_valid_e,
   input  logic                lsu_ale_e,
   input  logic                lsu_data_valid,
   input  logic                lsu_wr_fin,
   // outputs
   output logic                kill_e,
   output logic                lsu_go,
   output logic                except,
   output ecl_pkg::exc_code_e  exccode,
   output logic                stall_req
);
   import ecl_pkg::*;

   logic       valid_q;
   logic       valid_rise;
   logic       intr_pend;
   logic       intr_take;
   logic       lsu_fin;
   lsu_state_e state_q;
   lsu_state_e state_d;

   //////////////////////////////////////////////////////////////////////
   // interrupt
   //////////////////////////////////////////////////////////////////////

   // previous valid for edge detect
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         valid_q <= 1'b0;
      else
         valid_q <= valid_e;
   end

   assign valid_rise = valid_e & ~valid_q;

   // ext_intr acts as hardware line 0
   assign intr_pend = (timer_intr | ext_intr) & crmd_ie;

   // only taken on a fresh instruction
   // ie drops once except is seen, so this is a single pulse
   assign intr_take = intr_pend & valid_rise;

   // kill only on interrupt
   // ale is an e stage input and would close a loop through the lsu
   assign kill_e = intr_take;

   //////////////////////////////////////////////////////////////////////
   // exception
   //////////////////////////////////////////////////////////////////////

   // interrupt beats a faulting instruction, which is refetched later
   assign except  = intr_take | exception_e | lsu_ale_e;
   assign exccode = intr_take ? EXC_INT : exccode_e;

   //////////////////////////////////////////////////////////////////////
   // lsu stall
   //////////////////////////////////////////////////////////////////////

   assign lsu_go = lsu_valid_e & ~kill_e;

   // ale aborts the bus request, no data or write finish follows
   assign lsu_fin = lsu_data_valid | lsu_wr_fin | lsu_ale_e;

   always_comb begin
      state_d = state_q;
      case (state_q)
         LSU_IDLE: if (lsu_go && !lsu_fin) state_d = LSU_BUSY;
         LSU_BUSY: if (lsu_fin) state_d = LSU_IDLE;
         default:  state_d = LSU_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         state_q <= LSU_IDLE;
      else
         state_q <= state_d;
   end

   // covers the go cycle too, fetch must hold at once
   assign stall_req = lsu_go | (state_q == LSU_BUSY);

endmodule

// ==== hw/exu_ecl_top.sv ====
module exu_ecl_top #(
   parameter int XLEN = 32
) (
   input  logic               clk,
   input  logic               arst_n,
   // issue at e
   input  logic               valid_e,
   input  logic [XLEN-1:0]    alu_a_e,
   input  logic [XLEN-1:0]    alu_b_e,
   input  logic               alu_b_imm_e,
   input  logic               double_read_e,
   input  ecl_pkg::reg_idx_t  rs1_e,
   input  ecl_pkg::reg_idx_t  rs2_e,
   input  logic [XLEN-1:0]    imm_shifted_e,
   input  ecl_pkg::reg_idx_t  rf_target_e,
   input  logic               alu_wen_e,
   input  logic               lsu_valid_e,
   input  ecl_pkg::reg_idx_t  lsu_rd_e,
   input  logic               lsu_wen_e,
   input  logic               mul_valid_e,
   input  logic               mul_wen_e,
   input  logic               csr_valid_e,
   input  logic               csr_rdwen_e,
   input  logic [XLEN-1:0]    csr_rdata_d,
   input  logic               exception_e,
   input  ecl_pkg::exc_code_e exccode_e,
   // execution units
   input  logic [XLEN-1:0]    alu_res_e,
   input  logic [XLEN-1:0]    mul_res_m,
   input  logic [XLEN-1:0]    lsu_rdata_m,
   input  logic               lsu_data_valid,
   input  logic               lsu_wr_fin,
   input  logic               lsu_ale_e,
   input  logic               timer_intr,
   input  logic               ext_intr,
   input  logic               crmd_ie,
   // operands out
   output logic [XLEN-1:0]    alu_a,
   output logic [XLEN-1:0]    alu_b,
   output logic [XLEN-1:0]    lsu_base,
   output logic [XLEN-1:0]    lsu_offset,
   output logic [XLEN-1:0]    lsu_wdata,
   output logic               lsu_valid,
   output logic               mul_valid,
   // trap and fetch control
   output logic               except,
   output ecl_pkg::exc_code_e exccode,
   output logic               stall_req,
   // register file write port
   output logic               irf_wen_w,
   output ecl_pkg::reg_idx_t  irf_rd_w,
   output logic [XLEN-1:0]    irf_rd_data_w
);
   import ecl_pkg::*;

   logic            kill_e;
   logic            lsu_go;
   reg_idx_t        rd_m;
   logic            wen_m;
   logic [XLEN-1:0] rd_data_m;
   reg_idx_t        rd_w;
   logic            wen_w;
   logic [XLEN-1:0] rd_data_w;

   //////////////////////////////////////////////////////////////////////
   // trap and stall control
   //////////////////////////////////////////////////////////////////////

   ecl_trap_ctrl u_trap_ctrl (
      .clk            (clk),
      .arst_n         (arst_n),
      .valid_e        (valid_e),
      .exception_e    (exception_e),
      .exccode_e      (exccode_e),
      .timer_intr     (timer_intr),
      .ext_intr       (ext_intr),
      .crmd_ie        (crmd_ie),
      .lsu_valid_e    (lsu_valid_e),
      .lsu_ale_e      (lsu_ale_e),
      .lsu_data_valid (lsu_data_valid),
      .lsu_wr_fin     (lsu_wr_fin),
      .kill_e         (kill_e),
      .lsu_go         (lsu_go),
      .except         (except),
      .exccode        (exccode),
      .stall_req      (stall_req)
   );

   // lsu sees the valid after the kill
   assign lsu_valid = lsu_go;

   //////////////////////////////////////////////////////////////////////
   // writeback pipe
   //////////////////////////////////////////////////////////////////////

   ecl_writeback #(.XLEN(XLEN)) u_writeback (
      .clk            (clk),
      .arst_n         (arst_n),
      .kill_e         (kill_e),
      .lsu_go         (lsu_go),
      .rf_target_e    (rf_target_e),
      .alu_wen_e      (alu_wen_e),
      .alu_res_e      (alu_res_e),
      .mul_valid_e    (mul_valid_e),
      .mul_wen_e      (mul_wen_e),
      .mul_res_m      (mul_res_m),
      .csr_valid_e    (csr_valid_e),
      .csr_rdwen_e    (csr_rdwen_e),
      .csr_rdata_d    (csr_rdata_d),
      .lsu_rd_e       (lsu_rd_e),
      .lsu_wen_e      (lsu_wen_e),
      .lsu_data_valid (lsu_data_valid),
      .lsu_rdata_m    (lsu_rdata_m),
      .mul_valid      (mul_valid),
      .rd_m           (rd_m),
      .wen_m          (wen_m),
      .rd_data_m      (rd_data_m),
      .rd_w           (rd_w),
      .wen_w          (wen_w),
      .rd_data_w      (rd_data_w)
   );

   assign irf_wen_w     = wen_w;
   assign irf_rd_w      = rd_w;
   assign irf_rd_data_w = rd_data_w;

   // operand forwarding from m and w
   ecl_operand_bypass #(.XLEN(XLEN)) u_operand_bypass (
      .rs1_e         (rs1_e),
      .rs2_e         (rs2_e),
      .alu_a_e       (alu_a_e),
      .alu_b_e       (alu_b_e),
      .alu_b_imm_e   (alu_b_imm_e),
      .double_read_e (double_read_e),
      .imm_shifted_e (imm_shifted_e),
      .rd_m          (rd_m),
      .wen_m         (wen_m),
      .rd_data_m     (rd_data_m),
      .rd_w          (rd_w),
      .wen_w         (wen_w),
      .rd_data_w     (rd_data_w),
      .alu_a         (alu_a),
      .alu_b         (alu_b),
      .lsu_base      (lsu_base),
      .lsu_offset    (lsu_offset),
      .lsu_wdata     (lsu_wdata)
   );

endmodule

// ==== sim/tb_exu_ecl_sva.sv ====
module tb_exu_ecl_sva (
   input logic               clk,
   input logic               arst_n,
   input logic               valid_e,
   input logic               timer_intr,
   input logic               ext_intr,
   input logic               crmd_ie,
   input logic               kill_e,
   input logic               except,
   input ecl_pkg::exc_code_e exccode,
   input logic               stall_req,
   input logic               irf_wen_w
);
   timeunit 1ns;
   timeprecision 100ps;

   import ecl_pkg::*;

   // no stall request left over from reset
   assert property (@(posedge clk) $rose(arst_n) |-> !stall_req)
      else $error("stall_req high as reset ends");

   // a pending interrupt on a rising valid traps with EXC_INT
   assert property (@(posedge clk) disable iff (!arst_n)
                    ((timer_intr || ext_intr) && crmd_ie && valid_e && !$past(valid_e))
                    |-> (except && exccode == EXC_INT))
      else $error("interrupt taken without except and EXC_INT");

   // killed op reaches w two cycles on, no register write
   assert property (@(posedge clk) disable iff (!arst_n) kill_e |-> ##2 !irf_wen_w)
      else $error("killed instruction wrote the register file");

endmodule

bind exu_ecl_top tb_exu_ecl_sva u_sva (
   .clk        (clk),
   .arst_n     (arst_n),
   .valid_e    (valid_e),
   .timer_intr (timer_intr),
   .ext_intr   (ext_intr),
   .crmd_ie    (crmd_ie),
   .kill_e     (kill_e),
   .except     (except),
   .exccode    (exccode),
   .stall_req  (stall_req),
   .irf_wen_w  (irf_wen_w)
);

// ==== sim/tb_exu_ecl.sv ====
module tb_exu_ecl;
   timeunit 1ns;
   timeprecision 100ps;

   import ecl_pkg::*;

   localparam int XLEN         = 32;
   localparam int CLK_HALF     = 2;
   localparam int RESET_CYCLES = 5;
   localparam int ALU_RUNS     = 6;
   localparam int LOAD_WAIT    = 3;
   // reset, alu, forwarding, mul/csr, load/store, interrupt, tail
   localparam int TEST_CYCLES  = RESET_CYCLES + (ALU_RUNS + 2) + 9 + 4 + (LOAD_WAIT + 12) + 6 + 2;
   localparam int WATCHDOG_NS  = (TEST_CYCLES + 40) * 2 * CLK_HALF;

   logic clk;
   logic arst_n;
   logic valid_e;
   logic [XLEN-1:0] alu_a_e;
   logic [XLEN-1:0] alu_b_e;
   logic alu_b_imm_e;
   logic double_read_e;
   reg_idx_t rs1_e;
   reg_idx_t rs2_e;
   logic [XLEN-1:0] imm_shifted_e;
   reg_idx_t rf_target_e;
   logic alu_wen_e;
   logic lsu_valid_e;
   reg_idx_t lsu_rd_e;
   logic lsu_wen_e;
   logic mul_valid_e;
   logic mul_wen_e;
   logic csr_valid_e;
   logic csr_rdwen_e;
   logic [XLEN-1:0] csr_rdata_d;
   logic exception_e;
   exc_code_e exccode_e;
   logic [XLEN-1:0] alu_res_e;
   logic [XLEN-1:0] mul_res_m;
   logic [XLEN-1:0] lsu_rdata_m;
   logic lsu_data_valid;
   logic lsu_wr_fin;
   logic lsu_ale_e;
   logic timer_intr;
   logic ext_intr;
   logic crmd_ie;
   logic [XLEN-1:0] alu_a;
   logic [XLEN-1:0] alu_b;
   logic [XLEN-1:0] lsu_base;
   logic [XLEN-1:0] lsu_offset;
   logic [XLEN-1:0] lsu_wdata;
   logic lsu_valid;
   logic mul_valid;
   logic except;
   exc_code_e exccode;
   logic stall_req;
   logic irf_wen_w;
   reg_idx_t irf_rd_w;
   logic [XLEN-1:0] irf_rd_data_w;

   integer seed;
   int     n_checks;
   int     n_errors;

   exu_ecl_top #(.XLEN(XLEN)) uut (.*);

   //////////////////////////////////////////////////////////////////////
   // clock and watchdog
   //////////////////////////////////////////////////////////////////////

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // ends a hung run
   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
      $display("RESULT: FAIL");
      $finish;
   end

   //////////////////////////////////////////////////////////////////////
   // compare helpers
   //////////////////////////////////////////////////////////////////////

   task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                             input string what);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Fail %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_idx(input reg_idx_t got, input reg_idx_t exp, input string what);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Fail %0t ns: %s got r%0d expected r%0d", $time, what, got, exp);
      end
   endtask

   task automatic check_exc(input exc_code_e got, input exc_code_e exp, input string what);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Fail %0t ns: %s got %s expected %s", $time, what, got.name(), exp.name());
      end
   endtask

   // single control bits
   task automatic check_bit(input logic got, input logic exp, input string what);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Fail %0t ns: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic expect_writeback(input reg_idx_t rd, input logic [XLEN-1:0] data,
                                   input string what);
      check_bit(irf_wen_w, 1'b1, {what, " irf_wen_w"});
      check_idx(irf_rd_w, rd, {what, " irf_rd_w"});
      check_word(irf_rd_data_w, data, {what, " irf_rd_data_w"});
   endtask

   //////////////////////////////////////////////////////////////////////
   // stimulus helpers
   //////////////////////////////////////////////////////////////////////

   task automatic drive_idle();
      valid_e        = 1'b0;
      alu_a_e        = '0;
      alu_b_e        = '0;
      alu_b_imm_e    = 1'b0;
      double_read_e  = 1'b0;
      rs1_e          = '0;
      rs2_e          = '0;
      imm_shifted_e  = '0;
      rf_target_e    = '0;
      alu_wen_e      = 1'b0;
      lsu_valid_e    = 1'b0;
      lsu_rd_e       = '0;
      lsu_wen_e      = 1'b0;
      mul_valid_e    = 1'b0;
      mul_wen_e      = 1'b0;
      csr_valid_e    = 1'b0;
      csr_rdwen_e    = 1'b0;
      csr_rdata_d    = '0;
      exception_e    = 1'b0;
      exccode_e      = EXC_INT;
      alu_res_e      = '0;
      mul_res_m      = '0;
      lsu_rdata_m    = '0;
      lsu_data_valid = 1'b0;
      lsu_wr_fin     = 1'b0;
      lsu_ale_e      = 1'b0;
      timer_intr     = 1'b0;
      ext_intr       = 1'b0;
      crmd_ie        = 1'b0;
   endtask

   task automatic issue_alu(input reg_idx_t rd, input logic [XLEN-1:0] res, input logic wen);
      valid_e     = 1'b1;
      rf_target_e = rd;
      alu_res_e   = res;
      alu_wen_e   = wen;
   endtask

   //////////////////////////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////////////////////////

   // back to back alu results land two cycles later
   task automatic alu_back_to_back();
      reg_idx_t        q_rd[$];
      logic [XLEN-1:0] q_data[$];
      logic            q_wen[$];
      logic [31:0]     r;
      reg_idx_t        rd;
      logic [XLEN-1:0] data;
      logic            wen;
      for (int i = 0; i < ALU_RUNS + 2; i++) begin
         @(negedge clk);
         if (i >= 2) begin
            rd   = q_rd.pop_front();
            data = q_data.pop_front();
            wen  = q_wen.pop_front();
            if (wen)
               expect_writeback(rd, data, "alu");
            else
               check_bit(irf_wen_w, 1'b0, "alu with wen low");
         end
         drive_idle();
         if (i < ALU_RUNS) begin
            r    = $random(seed);
            rd   = r[REG_IDX_W-1:0];
            data = $random(seed);
            // one slot with the enable off
            wen  = (i != 3);
            issue_alu(rd, data, wen);
            q_rd.push_back(rd);
            q_data.push_back(data);
            q_wen.push_back(wen);
         end
      end
   endtask

   task automatic forward_operands();
      logic [XLEN-1:0] x1;
      logic [XLEN-1:0] x2;
      logic [XLEN-1:0] x3;
      logic [XLEN-1:0] y;
      x1 = $random(seed);
      x2 = $random(seed);
      x3 = $random(seed);
      y  = $random(seed);
      // producer into r5
      @(negedge clk);
      drive_idle();
      issue_alu(5'd5, x1, 1'b1);
      // consumer one behind sees m
      @(negedge clk);
      issue_alu(5'd9, y, 1'b0);
      rs1_e   = 5'd5;
      alu_a_e = y;
      #1;
      check_word(alu_a, x1, "alu_a from m");
      check_word(lsu_base, x1, "lsu_base from m");
      // two behind sees w
      @(negedge clk);
      #1;
      check_word(alu_a, x1, "alu_a from w");
      // two producers into r7, younger one wins
      @(negedge clk);
      drive_idle();
      issue_alu(5'd7, x2, 1'b1);
      @(negedge clk);
      issue_alu(5'd7, x3, 1'b1);
      @(negedge clk);
      issue_alu(5'd9, y, 1'b0);
      rs1_e   = 5'd7;
      rs2_e   = 5'd7;
      alu_a_e = y;
      alu_b_e = y;
      #1;
      check_word(alu_a, x3, "alu_a m over w");
      check_word(alu_b, x3, "alu_b m over w");
      check_word(lsu_wdata, x3, "lsu_wdata m over w");
      // r7 still at w, immediate form ignores it
      @(negedge clk);
      drive_idle();
      issue_alu(5'd0, x1, 1'b1);
      rs2_e         = 5'd7;
      alu_b_e       = y;
      alu_b_imm_e   = 1'b1;
      imm_shifted_e = x2;
      #1;
      check_word(alu_b, y, "alu_b immediate");
      check_word(lsu_offset, x2, "lsu_offset immediate");
      // r0 write sits in m, never forwarded
      @(negedge clk);
      drive_idle();
      rs1_e   = 5'd0;
      alu_a_e = y;
      #1;
      check_word(alu_a, y, "alu_a r0");
   endtask

   task automatic mul_csr_writeback();
      logic [XLEN-1:0] m_res;
      logic [XLEN-1:0] c_res;
      m_res = $random(seed);
      c_res = $random(seed);
      // mul at e, csr data one cycle ahead of its e
      @(negedge clk);
      drive_idle();
      valid_e     = 1'b1;
      mul_valid_e = 1'b1;
      mul_wen_e   = 1'b1;
      rf_target_e = 5'd12;
      csr_rdata_d = c_res;
      #1;
      check_bit(mul_valid, 1'b1, "mul_valid");
      // mul result at m, csr read at e
      @(negedge clk);
      drive_idle();
      valid_e     = 1'b1;
      mul_res_m   = m_res;
      csr_valid_e = 1'b1;
      csr_rdwen_e = 1'b1;
      rf_target_e = 5'd13;
      @(negedge clk);
      expect_writeback(5'd12, m_res, "mul");
      drive_idle();
      @(negedge clk);
      expect_writeback(5'd13, c_res, "csr");
   endtask

   task automatic load_store_stall();
      logic [31:0]     r;
      reg_idx_t        ld_rd;
      logic [XLEN-1:0] ld_data;
      r       = $random(seed);
      ld_rd   = r[REG_IDX_W-1:0];
      ld_data = $random(seed);
      // load, stall from the go cycle
      @(negedge clk);
      drive_idle();
      valid_e     = 1'b1;
      lsu_valid_e = 1'b1;
      lsu_rd_e    = ld_rd;
      lsu_wen_e   = 1'b1;
      #1;
      check_bit(lsu_valid, 1'b1, "lsu_valid on load");
      check_bit(stall_req, 1'b1, "stall_req load issue");
      repeat (LOAD_WAIT) begin
         @(negedge clk);
         drive_idle();
         #1;
         check_bit(stall_req, 1'b1, "stall_req load busy");
      end
      @(negedge clk);
      lsu_data_valid = 1'b1;
      lsu_rdata_m    = ld_data;
      #1;
      check_bit(stall_req, 1'b1, "stall_req data valid");
      @(negedge clk);
      expect_writeback(ld_rd, ld_data, "load");
      drive_idle();
      #1;
      check_bit(stall_req, 1'b0, "stall_req after load");
      // store ends on write finish
      @(negedge clk);
      valid_e     = 1'b1;
      lsu_valid_e = 1'b1;
      #1;
      check_bit(stall_req, 1'b1, "stall_req store issue");
      @(negedge clk);
      drive_idle();
      lsu_wr_fin = 1'b1;
      #1;
      check_bit(stall_req, 1'b1, "stall_req write finish");
      @(negedge clk);
      check_bit(irf_wen_w, 1'b0, "store irf_wen_w");
      drive_idle();
      #1;
      check_bit(stall_req, 1'b0, "stall_req after store");
      // misaligned access aborts and traps
      @(negedge clk);
      valid_e     = 1'b1;
      lsu_valid_e = 1'b1;
      lsu_rd_e    = ld_rd;
      lsu_wen_e   = 1'b1;
      @(negedge clk);
      drive_idle();
      lsu_ale_e = 1'b1;
      exccode_e = EXC_ALE;
      #1;
      check_bit(stall_req, 1'b1, "stall_req ale cycle");
      check_bit(except, 1'b1, "except on ale");
      check_exc(exccode, EXC_ALE, "exccode on ale");
      @(negedge clk);
      drive_idle();
      #1;
      check_bit(stall_req, 1'b0, "stall_req after ale");
      check_bit(except, 1'b0, "except after ale");
   endtask

   task automatic interrupt_kill();
      logic [XLEN-1:0] x;
      x = $random(seed);
      // pending but valid low, nothing taken
      @(negedge clk);
      drive_idle();
      ext_intr = 1'b1;
      crmd_ie  = 1'b1;
      #1;
      check_bit(except, 1'b0, "except without valid edge");
      // rising valid takes it and kills the alu op
      @(negedge clk);
      issue_alu(5'd3, x, 1'b1);
      #1;
      check_bit(except, 1'b1, "except on interrupt");
      check_exc(exccode, EXC_INT, "exccode on interrupt");
      // valid held, no new edge
      @(negedge clk);
      alu_wen_e = 1'b0;
      #1;
      check_bit(except, 1'b0, "except valid held");
      @(negedge clk);
      check_bit(irf_wen_w, 1'b0, "killed op irf_wen_w");
      valid_e = 1'b0;
      crmd_ie = 1'b0;
      // masked, fetch exception code passes through
      @(negedge clk);
      valid_e     = 1'b1;
      exception_e = 1'b1;
      exccode_e   = EXC_SYS;
      #1;
      check_bit(except, 1'b1, "except masked");
      check_exc(exccode, EXC_SYS, "exccode masked");
      @(negedge clk);
      drive_idle();
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      seed     = 65;
      n_checks = 0;
      n_errors = 0;
      arst_n   = 1'b0;
      drive_idle();
      repeat (RESET_CYCLES) @(negedge clk);
      arst_n = 1'b1;
      #1;
      check_bit(irf_wen_w, 1'b0, "irf_wen_w after reset");
      check_bit(stall_req, 1'b0, "stall_req after reset");
      alu_back_to_back();
      forward_operands();
      mul_csr_writeback();
      load_store_stall();
      interrupt_kill();
      repeat (2) @(negedge clk);
      $display("checks run %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// ==== vlog.f ====
hw/ecl_pkg.sv
hw/ecl_operand_bypass.sv
hw/ecl_writeback.sv
hw/ecl_trap_ctrl.sv
hw/exu_ecl_top.sv
sim/tb_exu_ecl_sva.sv
sim/tb_exu_ecl.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_exu_ecl -Mdir obj_dir -f vlog.f &&
   ./obj_dir/Vtb_exu_ecl | tee /dev/stderr | grep -qx "RESULT: PASS" &&
   echo "simulation passed" ||
   { echo "simulation failed"; exit 1; }
